// File: hdl/manycore_lite_config.svh
// Build constants for the manycore lite shell wrapper
`ifndef MANYCORE_LITE_CONFIG_SVH
`define MANYCORE_LITE_CONFIG_SVH

// ----------------------------------------
// Column memory geometry
// ----------------------------------------
`define MCL_NUM_COLS      4
`define MCL_COL_WORDS     256
`define MCL_DATA_W        32

// ----------------------------------------
// Shell identification and LED
// ----------------------------------------
// Vendor and device in ID0, subsystem in ID1
`define MCL_ID0           32'hC01A_0001
`define MCL_ID1           32'h4D43_0100

// Fixed LED value once out of reset
`define MCL_VLED_PATTERN  16'hBEEF

`endif

// File: hdl/manycore_lite_pkg.sv
// Shared types for host address decode, AXI responses and status registers
package manycore_lite_pkg;

   typedef logic [1:0] col_idx_t;
   typedef logic [7:0] word_idx_t;

   // Status register index
   typedef enum logic [1:0] {
      CSR_ID0  = 2'd0,
      CSR_ID1  = 2'd1,
      CSR_VDIP = 2'd2,
      CSR_COLS = 2'd3
   } csr_reg_e;

   // Memory view of the host offset, region bit is 0
   typedef struct packed {
      logic       region;
      logic [2:0] unused;
      col_idx_t   col;
      word_idx_t  index;
      logic [1:0] byte_off;
   } mem_addr_t;

   // Status view of the host offset, region bit is 1
   typedef struct packed {
      logic        region;
      logic [10:0] unused;
      csr_reg_e    reg_idx;
      logic [1:0]  byte_off;
   } csr_addr_t;

   typedef union packed {
      mem_addr_t mem;
      csr_addr_t csr;
   } host_addr_u;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

endpackage

// File: hdl/host_link_if.sv
// Single decoded host request and its reply, shared by port, dispatcher and collector
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

interface host_link_if;
   import manycore_lite_pkg::*;

   // Request, one-cycle pulse from the host port
   logic                     req_valid;
   logic                     req_write;
   host_addr_u               req_addr;
   logic [`MCL_DATA_W-1:0]   req_wdata;
   logic [`MCL_DATA_W/8-1:0] req_wstrb;

   // Reply, exactly one cycle after the request
   logic                     rsp_valid;
   logic [`MCL_DATA_W-1:0]   rsp_rdata;
   logic                     rsp_err;

   modport port (
      output req_valid, req_write, req_addr, req_wdata, req_wstrb,
      input  rsp_valid, rsp_rdata, rsp_err
   );

   modport dispatch (
      input  req_valid, req_write, req_addr, req_wdata, req_wstrb
   );

   modport collect (
      output rsp_valid, rsp_rdata, rsp_err
   );

endinterface

// File: hdl/col_link_if.sv
// Request and reply link between the dispatcher, one column and the collector
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

interface col_link_if;
   import manycore_lite_pkg::*;

   logic                     req_valid;
   logic                     req_write;
   word_idx_t                req_index;
   logic [`MCL_DATA_W-1:0]   req_wdata;
   logic [`MCL_DATA_W/8-1:0] req_wstrb;

   // Driven by the column one cycle after req_valid
   logic                     rsp_valid;
   logic [`MCL_DATA_W-1:0]   rsp_rdata;

   modport dispatch (
      output req_valid, req_write, req_index, req_wdata, req_wstrb
   );

   modport column (
      input  req_valid, req_write, req_index, req_wdata, req_wstrb,
      output rsp_valid, rsp_rdata
   );

   modport collect (
      input  rsp_valid, rsp_rdata
   );

endinterface

// File: hdl/axil_host_port.sv
// AXI4-Lite slave that takes one read or write at a time and issues it on the host link
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module axil_host_port (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic [31:0]              s_awaddr_i,
   input  logic                     s_awvalid_i,
   output logic                     s_awready_o,
   input  logic [`MCL_DATA_W-1:0]   s_wdata_i,
   input  logic [`MCL_DATA_W/8-1:0] s_wstrb_i,
   input  logic                     s_wvalid_i,
   output logic                     s_wready_o,
   output logic [1:0]               s_bresp_o,
   output logic                     s_bvalid_o,
   input  logic                     s_bready_i,
   input  logic [31:0]              s_araddr_i,
   input  logic                     s_arvalid_i,
   output logic                     s_arready_o,
   output logic [`MCL_DATA_W-1:0]   s_rdata_o,
   output logic [1:0]               s_rresp_o,
   output logic                     s_rvalid_o,
   input  logic                     s_rready_i,
   host_link_if.port                host_link
);
   import manycore_lite_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_RESP
   } state_e;

   state_e                   state_q;
   state_e                   state_d;
   logic                     write_q;
   host_addr_u               addr_q;
   logic [`MCL_DATA_W-1:0]   wdata_q;
   logic [`MCL_DATA_W/8-1:0] wstrb_q;
   logic [`MCL_DATA_W-1:0]   rdata_q;
   logic                     err_q;
   logic                     wr_go;
   logic                     rd_go;
   logic                     rsp_done;

   // ----------------------------------------
   // Accept, writes first
   // ----------------------------------------
   // Write needs address and data together; read waits while any write is pending
   assign wr_go = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
   assign rd_go = (state_q == ST_IDLE) && s_arvalid_i && !s_awvalid_i && !s_wvalid_i;

   assign s_awready_o = wr_go;
   assign s_wready_o  = wr_go;
   assign s_arready_o = rd_go;

   assign rsp_done = (s_bvalid_o && s_bready_i) || (s_rvalid_o && s_rready_i);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:  if (wr_go || rd_go) state_d = ST_ISSUE;
         ST_ISSUE: state_d = ST_WAIT;
         ST_WAIT:  if (host_link.rsp_valid) state_d = ST_RESP;
         ST_RESP:  if (rsp_done) state_d = ST_IDLE;
         default:  state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         state_q <= ST_IDLE;
         write_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (wr_go || rd_go) begin
            write_q <= wr_go;
         end
      end
   end

   // Request and reply holding registers
   always_ff @(posedge clk_main_a0) begin
      if (wr_go) begin
         addr_q  <= s_awaddr_i[15:0];
         wdata_q <= s_wdata_i;
         wstrb_q <= s_wstrb_i;
      end else if (rd_go) begin
         addr_q  <= s_araddr_i[15:0];
      end
      if ((state_q == ST_WAIT) && host_link.rsp_valid) begin
         rdata_q <= host_link.rsp_rdata;
         err_q   <= host_link.rsp_err;
      end
   end

   // ----------------------------------------
   // Host link request
   // ----------------------------------------
   assign host_link.req_valid = (state_q == ST_ISSUE);
   assign host_link.req_write = write_q;
   assign host_link.req_addr  = addr_q;
   assign host_link.req_wdata = wdata_q;
   assign host_link.req_wstrb = wstrb_q;

   // Reply held until the master takes it
   assign s_bvalid_o = (state_q == ST_RESP) && write_q;
   assign s_rvalid_o = (state_q == ST_RESP) && !write_q;
   assign s_bresp_o  = err_q ? SLVERR : OKAY;
   assign s_rresp_o  = err_q ? SLVERR : OKAY;
   assign s_rdata_o  = rdata_q;

endmodule

// File: hdl/column_dispatch.sv
// Address decoder that steers a host request to one column or to the status block
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module column_dispatch (
   host_link_if.dispatch                host_link,
   col_link_if.dispatch                 col_link [`MCL_NUM_COLS],
   output logic                         csr_valid_o,
   output logic                         csr_write_o,
   output manycore_lite_pkg::csr_reg_e  csr_reg_o
);
   import manycore_lite_pkg::*;

   logic     is_csr;
   col_idx_t sel_col;

   // Region bit is common to both views
   assign is_csr  = host_link.req_addr.csr.region;
   assign sel_col = host_link.req_addr.mem.col;

   // ----------------------------------------
   // Memory columns
   // ----------------------------------------
   for (genvar c = 0; c < `MCL_NUM_COLS; c++) begin : g_col
      assign col_link[c].req_valid = host_link.req_valid && !is_csr
                                     && (sel_col == col_idx_t'(c));
      assign col_link[c].req_write = host_link.req_write;
      assign col_link[c].req_index = host_link.req_addr.mem.index;
      assign col_link[c].req_wdata = host_link.req_wdata;
      assign col_link[c].req_wstrb = host_link.req_wstrb;
   end

   // ----------------------------------------
   // Status block
   // ----------------------------------------
   // Write data is not needed, every status write is refused
   assign csr_valid_o = host_link.req_valid && is_csr;
   assign csr_write_o = host_link.req_write;
   assign csr_reg_o   = host_link.req_addr.csr.reg_idx;

endmodule

// File: hdl/column_mem.sv
// Per-column word memory with byte write strobes and a registered reply
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module column_mem (
   input  logic        clk_main_a0,
   input  logic        rst_main_n_sync,
   col_link_if.column  col_link
);

   localparam int BYTES = `MCL_DATA_W / 8;

   logic [`MCL_DATA_W-1:0] mem [`MCL_COL_WORDS];
   logic [`MCL_DATA_W-1:0] rdata_q;
   logic                   rsp_valid_q;

   // ----------------------------------------
   // Storage
   // ----------------------------------------
   always_ff @(posedge clk_main_a0) begin
      if (col_link.req_valid && col_link.req_write) begin
         for (int b = 0; b < BYTES; b++) begin
            if (col_link.req_wstrb[b]) begin
               mem[col_link.req_index][b*8 +: 8] <= col_link.req_wdata[b*8 +: 8];
            end
         end
      end
   end

   // Read port, one cycle latency
   always_ff @(posedge clk_main_a0) begin
      if (col_link.req_valid && !col_link.req_write) begin
         rdata_q <= mem[col_link.req_index];
      end
   end

   // ----------------------------------------
   // Reply
   // ----------------------------------------
   // Writes also answer so the host port sees a reply for every request
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= col_link.req_valid;
      end
   end

   assign col_link.rsp_valid = rsp_valid_q;
   assign col_link.rsp_rdata = rdata_q;

endmodule

// File: hdl/shell_status.sv
// Shell status block with switch synchronizer, LED register and read-only ID registers
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module shell_status (
   input  logic                         clk_main_a0,
   input  logic                         rst_main_n_sync,
   input  logic                         csr_valid_i,
   input  logic                         csr_write_i,
   input  manycore_lite_pkg::csr_reg_e  csr_reg_i,
   input  logic [15:0]                  status_vdip_i,
   output logic [15:0]                  status_vled_o,
   output logic                         csr_rsp_valid_o,
   output logic [`MCL_DATA_W-1:0]       csr_rsp_rdata_o,
   output logic                         csr_rsp_err_o
);
   import manycore_lite_pkg::*;

   localparam logic [`MCL_DATA_W-1:0] COLS_WORD = `MCL_NUM_COLS;

   logic [15:0]            vdip_q;
   logic [15:0]            vdip_q2;
   logic [`MCL_DATA_W-1:0] rd_word;

   // ----------------------------------------
   // Switches and LED
   // ----------------------------------------
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         vdip_q        <= '0;
         vdip_q2       <= '0;
         status_vled_o <= '0;
      end else begin
         vdip_q        <= status_vdip_i;
         vdip_q2       <= vdip_q;
         status_vled_o <= `MCL_VLED_PATTERN;
      end
   end

   // ----------------------------------------
   // Register read mux
   // ----------------------------------------
   always_comb begin
      case (csr_reg_i)
         CSR_ID0:  rd_word = `MCL_ID0;
         CSR_ID1:  rd_word = `MCL_ID1;
         CSR_VDIP: rd_word = {{(`MCL_DATA_W-16){1'b0}}, vdip_q2};
         default:  rd_word = COLS_WORD;
      endcase
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         csr_rsp_valid_o <= 1'b0;
      end else begin
         csr_rsp_valid_o <= csr_valid_i;
      end
   end

   // All registers are read-only, a write gets an error and zero data
   always_ff @(posedge clk_main_a0) begin
      if (csr_valid_i) begin
         csr_rsp_rdata_o <= csr_write_i ? '0 : rd_word;
         csr_rsp_err_o   <= csr_write_i;
      end
   end

endmodule

// File: hdl/response_collect.sv
// Merges the column and status replies into the one host reply
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module response_collect (
   host_link_if.collect            host_link,
   col_link_if.collect             col_link [`MCL_NUM_COLS],
   input  logic                    csr_rsp_valid_i,
   input  logic [`MCL_DATA_W-1:0]  csr_rsp_rdata_i,
   input  logic                    csr_rsp_err_i
);

   logic [`MCL_NUM_COLS-1:0] col_valid;
   logic [`MCL_DATA_W-1:0]   col_rdata [`MCL_NUM_COLS];
   logic [`MCL_DATA_W-1:0]   rdata;

   // Mask each column's data with its own valid
   for (genvar c = 0; c < `MCL_NUM_COLS; c++) begin : g_col
      assign col_valid[c] = col_link[c].rsp_valid;
      assign col_rdata[c] = col_link[c].rsp_valid ? col_link[c].rsp_rdata : '0;
   end

   // ----------------------------------------
   // AND-OR select
   // ----------------------------------------
   // At most one reply is valid in any cycle
   always_comb begin
      rdata = csr_rsp_valid_i ? csr_rsp_rdata_i : '0;
      for (int c = 0; c < `MCL_NUM_COLS; c++) begin
         rdata = rdata | col_rdata[c];
      end
   end

   assign host_link.rsp_valid = (|col_valid) || csr_rsp_valid_i;
   assign host_link.rsp_rdata = rdata;
   // only the status block can fail
   assign host_link.rsp_err   = csr_rsp_valid_i && csr_rsp_err_i;

endmodule

// File: hdl/manycore_lite_top.sv
// Top level of the host-visible shell with column memories and status block
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module manycore_lite_top (
   input  logic                     clk_main_a0,
   input  logic                     rst_main_n_sync,
   input  logic [31:0]              s_awaddr_i,
   input  logic                     s_awvalid_i,
   output logic                     s_awready_o,
   input  logic [`MCL_DATA_W-1:0]   s_wdata_i,
   input  logic [`MCL_DATA_W/8-1:0] s_wstrb_i,
   input  logic                     s_wvalid_i,
   output logic                     s_wready_o,
   output logic [1:0]               s_bresp_o,
   output logic                     s_bvalid_o,
   input  logic                     s_bready_i,
   input  logic [31:0]              s_araddr_i,
   input  logic                     s_arvalid_i,
   output logic                     s_arready_o,
   output logic [`MCL_DATA_W-1:0]   s_rdata_o,
   output logic [1:0]               s_rresp_o,
   output logic                     s_rvalid_o,
   input  logic                     s_rready_i,
   input  logic [15:0]              status_vdip_i,
   output logic [15:0]              status_vled_o
);
   import manycore_lite_pkg::*;

   // ----------------------------------------
   // Links
   // ----------------------------------------
   host_link_if host_link ();
   col_link_if  col_links [`MCL_NUM_COLS] ();

   logic                   csr_valid;
   logic                   csr_write;
   csr_reg_e               csr_reg;
   logic                   csr_rsp_valid;
   logic [`MCL_DATA_W-1:0] csr_rsp_rdata;
   logic                   csr_rsp_err;

   axil_host_port axil_host_port_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .s_awaddr_i      (s_awaddr_i),
      .s_awvalid_i     (s_awvalid_i),
      .s_awready_o     (s_awready_o),
      .s_wdata_i       (s_wdata_i),
      .s_wstrb_i       (s_wstrb_i),
      .s_wvalid_i      (s_wvalid_i),
      .s_wready_o      (s_wready_o),
      .s_bresp_o       (s_bresp_o),
      .s_bvalid_o      (s_bvalid_o),
      .s_bready_i      (s_bready_i),
      .s_araddr_i      (s_araddr_i),
      .s_arvalid_i     (s_arvalid_i),
      .s_arready_o     (s_arready_o),
      .s_rdata_o       (s_rdata_o),
      .s_rresp_o       (s_rresp_o),
      .s_rvalid_o      (s_rvalid_o),
      .s_rready_i      (s_rready_i),
      .host_link       (host_link)
   );

   column_dispatch column_dispatch_i (
      .host_link   (host_link),
      .col_link    (col_links),
      .csr_valid_o (csr_valid),
      .csr_write_o (csr_write),
      .csr_reg_o   (csr_reg)
   );

   // One memory per column
   for (genvar c = 0; c < `MCL_NUM_COLS; c++) begin : g_col
      column_mem column_mem_i (
         .clk_main_a0     (clk_main_a0),
         .rst_main_n_sync (rst_main_n_sync),
         .col_link        (col_links[c])
      );
   end

   shell_status shell_status_i (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .csr_valid_i     (csr_valid),
      .csr_write_i     (csr_write),
      .csr_reg_i       (csr_reg),
      .status_vdip_i   (status_vdip_i),
      .status_vled_o   (status_vled_o),
      .csr_rsp_valid_o (csr_rsp_valid),
      .csr_rsp_rdata_o (csr_rsp_rdata),
      .csr_rsp_err_o   (csr_rsp_err)
   );

   response_collect response_collect_i (
      .host_link       (host_link),
      .col_link        (col_links),
      .csr_rsp_valid_i (csr_rsp_valid),
      .csr_rsp_rdata_i (csr_rsp_rdata),
      .csr_rsp_err_i   (csr_rsp_err)
   );

endmodule

// File: tb/tb_manycore_lite.sv
// Random self-checking testbench for the manycore lite shell with a column memory model
`timescale 1ns/1ps
`include "manycore_lite_config.svh"

module tb_manycore_lite;

   localparam int          TIMEOUT_CYCLES = 50;
   localparam logic [31:0] CSR_BASE       = 32'h0000_8000;
   localparam logic [1:0]  RESP_OKAY      = 2'b00;
   localparam logic [1:0]  RESP_SLVERR    = 2'b10;

   logic        clk_main_a0;
   logic        rst_main_n_sync;
   logic [31:0] s_awaddr_i;
   logic        s_awvalid_i;
   logic        s_awready_o;
   logic [31:0] s_wdata_i;
   logic [3:0]  s_wstrb_i;
   logic        s_wvalid_i;
   logic        s_wready_o;
   logic [1:0]  s_bresp_o;
   logic        s_bvalid_o;
   logic        s_bready_i;
   logic [31:0] s_araddr_i;
   logic        s_arvalid_i;
   logic        s_arready_o;
   logic [31:0] s_rdata_o;
   logic [1:0]  s_rresp_o;
   logic        s_rvalid_o;
   logic        s_rready_i;
   logic [15:0] status_vdip_i;
   logic [15:0] status_vled_o;

   // Expected contents of every column
   logic [31:0] model_mem [`MCL_NUM_COLS][`MCL_COL_WORDS];
   logic [31:0] rng_state;
   int          error_count;
   int          timeout_count;
   // Largest random BREADY/RREADY delay where 0 takes responses at once
   int          bp_max;

   manycore_lite_top manycore_lite_top_i (.*);

   initial begin
      clk_main_a0 = 1'b0;
      forever begin
         #50 clk_main_a0 = ~clk_main_a0;
      end
   end

   // ----------------------------------------
   // Random numbers and model helpers
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Upper half is random since only the low 16 bits are decoded
   function automatic logic [31:0] mem_addr(input int col, input int idx);
      logic [31:0] r;
      r = next_rand();
      return {r[31:16], 1'b0, 3'b000, col[1:0], idx[7:0], 2'b00};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
         input logic [31:0] new_word, input logic [3:0] strb);
      logic [31:0] r;
      r = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            r[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return r;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      error_count++;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES);
      timeout_count++;
   endtask

   // ----------------------------------------
   // AXI4-Lite master
   // ----------------------------------------
   // Completes the read that was raised while a response was held
   task automatic finish_probe_read();
      int          cnt;
      bit          seen;
      logic [1:0]  resp;
      logic [31:0] rdata;
      seen = 1'b0;
      cnt  = 0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_main_a0);
         seen = s_arready_o;
         cnt++;
      end
      @(negedge clk_main_a0);
      s_arvalid_i = 1'b0;
      if (!seen) begin
         report_timeout("probe read address handshake");
         return;
      end
      seen = 1'b0;
      cnt  = 0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_main_a0);
         seen = s_rvalid_o;
         cnt++;
      end
      if (!seen) begin
         report_timeout("probe read response");
         return;
      end
      resp  = s_rresp_o;
      rdata = s_rdata_o;
      @(negedge clk_main_a0);
      s_rready_i = 1'b1;
      @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      s_rready_i = 1'b0;
      if (resp !== RESP_OKAY) begin
         report_mismatch("probe read resp", RESP_OKAY, resp);
      end
      if (rdata !== `MCL_ID0) begin
         report_mismatch("probe read", `MCL_ID0, rdata);
      end
   endtask

   // Waits for B or R and holds ready low for a random delay before taking it
   task automatic take_response(input bit is_write, output logic [1:0] resp,
         output logic [31:0] rdata);
      int cnt;
      int delay;
      int i;
      bit seen;
      resp  = 2'bxx;
      rdata = 'x;
      seen  = 1'b0;
      cnt   = 0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_main_a0);
         seen = is_write ? s_bvalid_o : s_rvalid_o;
         cnt++;
      end
      if (!seen) begin
         report_timeout(is_write ? "write response" : "read response");
         return;
      end
      resp  = is_write ? s_bresp_o : s_rresp_o;
      rdata = s_rdata_o;
      delay = (bp_max > 0) ? int'(next_rand() % (bp_max + 1)) : 0;
      if (delay > 0) begin
         @(negedge clk_main_a0);
         // Probe read that must wait until the held response is taken
         s_araddr_i  = CSR_BASE;
         s_arvalid_i = 1'b1;
      end
      for (i = 0; i < delay; i++) begin
         @(posedge clk_main_a0);
         if ((is_write ? s_bvalid_o : s_rvalid_o) !== 1'b1) begin
            report_mismatch("valid held", 1, is_write ? s_bvalid_o : s_rvalid_o);
         end
         if ((is_write ? s_bresp_o : s_rresp_o) !== resp) begin
            report_mismatch("resp held", resp, is_write ? s_bresp_o : s_rresp_o);
         end
         if (!is_write && s_rdata_o !== rdata) begin
            report_mismatch("rdata held", rdata, s_rdata_o);
         end
         if (s_arready_o !== 1'b0) begin
            report_mismatch("arready while response held", 0, s_arready_o);
         end
      end
      @(negedge clk_main_a0);
      s_bready_i  = is_write;
      s_rready_i  = !is_write;
      @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      s_bready_i = 1'b0;
      s_rready_i = 1'b0;
      if (delay > 0) begin
         finish_probe_read();
      end
   endtask

   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
         input logic [3:0] strb, output logic [1:0] resp);
      int          cnt;
      bit          seen;
      logic [31:0] rsp_data;
      resp = 2'bxx;
      if (timeout_count != 0) begin
         return;
      end
      @(negedge clk_main_a0);
      s_awaddr_i  = addr;
      s_awvalid_i = 1'b1;
      s_wdata_i   = data;
      s_wstrb_i   = strb;
      s_wvalid_i  = 1'b1;
      seen = 1'b0;
      cnt  = 0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_main_a0);
         seen = s_awready_o && s_wready_o;
         cnt++;
      end
      @(negedge clk_main_a0);
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      if (!seen) begin
         report_timeout("write address and data handshake");
         return;
      end
      take_response(1'b1, resp, rsp_data);
   endtask

   task automatic axil_read(input logic [31:0] addr, output logic [1:0] resp,
         output logic [31:0] data);
      int cnt;
      bit seen;
      resp = 2'bxx;
      data = 'x;
      if (timeout_count != 0) begin
         return;
      end
      @(negedge clk_main_a0);
      s_araddr_i  = addr;
      s_arvalid_i = 1'b1;
      seen = 1'b0;
      cnt  = 0;
      while (!seen && cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_main_a0);
         seen = s_arready_o;
         cnt++;
      end
      @(negedge clk_main_a0);
      s_arvalid_i = 1'b0;
      if (!seen) begin
         report_timeout("read address handshake");
         return;
      end
      take_response(1'b0, resp, data);
   endtask

   // ----------------------------------------
   // Checked accesses
   // ----------------------------------------
   task automatic write_mem(input int col, input int idx, input logic [31:0] data,
         input logic [3:0] strb, input string name);
      logic [1:0] resp;
      axil_write(mem_addr(col, idx), data, strb, resp);
      model_mem[col][idx] = merge_bytes(model_mem[col][idx], data, strb);
      if (timeout_count == 0 && resp !== RESP_OKAY) begin
         report_mismatch($sformatf("%s resp col %0d word %0d", name, col, idx),
                         RESP_OKAY, resp);
      end
   endtask

   task automatic check_mem_read(input int col, input int idx, input string name);
      logic [1:0]  resp;
      logic [31:0] data;
      axil_read(mem_addr(col, idx), resp, data);
      if (timeout_count == 0 && resp !== RESP_OKAY) begin
         report_mismatch($sformatf("%s resp col %0d word %0d", name, col, idx),
                         RESP_OKAY, resp);
      end
      if (timeout_count == 0 && data !== model_mem[col][idx]) begin
         report_mismatch($sformatf("%s col %0d word %0d", name, col, idx),
                         model_mem[col][idx], data);
      end
   endtask

   task automatic read_csr(input int reg_idx, input logic [31:0] expected,
         input string name);
      logic [1:0]  resp;
      logic [31:0] data;
      axil_read(CSR_BASE + 32'(reg_idx * 4), resp, data);
      if (timeout_count == 0 && resp !== RESP_OKAY) begin
         report_mismatch({name, " resp"}, RESP_OKAY, resp);
      end
      if (timeout_count == 0 && data !== expected) begin
         report_mismatch(name, expected, data);
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [1:0]  resp;
      logic [31:0] r;
      logic [15:0] vdip;
      int          col;
      int          idx;
      s_awaddr_i      = '0;
      s_awvalid_i     = 1'b0;
      s_wdata_i       = '0;
      s_wstrb_i       = '0;
      s_wvalid_i      = 1'b0;
      s_bready_i      = 1'b0;
      s_araddr_i      = '0;
      s_arvalid_i     = 1'b0;
      s_rready_i      = 1'b0;
      status_vdip_i   = '0;
      rst_main_n_sync = 1'b0;
      rng_state       = 32'd17;
      error_count     = 0;
      timeout_count   = 0;
      bp_max          = 0;

      // LED is cleared in reset and shows the pattern right after it
      repeat (3) @(negedge clk_main_a0);
      if (status_vled_o !== 16'h0000) begin
         report_mismatch("vled during reset", 0, status_vled_o);
      end
      repeat (2) @(negedge clk_main_a0);
      rst_main_n_sync = 1'b1;
      @(negedge clk_main_a0);
      if (status_vled_o !== `MCL_VLED_PATTERN) begin
         report_mismatch("vled after reset", `MCL_VLED_PATTERN, status_vled_o);
      end

      // Fill every word, then read all back
      for (col = 0; col < `MCL_NUM_COLS; col++) begin
         for (idx = 0; idx < `MCL_COL_WORDS; idx++) begin
            write_mem(col, idx, next_rand(), 4'hF, "fill write");
         end
      end
      for (col = 0; col < `MCL_NUM_COLS; col++) begin
         for (idx = 0; idx < `MCL_COL_WORDS; idx++) begin
            check_mem_read(col, idx, "fill read");
         end
      end
      repeat (300) begin
         col = next_rand() % `MCL_NUM_COLS;
         idx = next_rand() % `MCL_COL_WORDS;
         r   = next_rand();
         if (r[0]) begin
            write_mem(col, idx, next_rand(), 4'hF, "random write");
         end else begin
            check_mem_read(col, idx, "random read");
         end
      end

      // Byte strobes
      repeat (200) begin
         col = next_rand() % `MCL_NUM_COLS;
         idx = next_rand() % `MCL_COL_WORDS;
         r   = next_rand();
         write_mem(col, idx, next_rand(), r[3:0], "partial write");
         check_mem_read(col, idx, "partial read");
      end

      // Status registers are read-only
      read_csr(0, `MCL_ID0, "ID0 read");
      read_csr(1, `MCL_ID1, "ID1 read");
      read_csr(3, `MCL_NUM_COLS, "COLS read");
      for (idx = 0; idx < 4; idx++) begin
         axil_write(CSR_BASE + 32'(idx * 4), next_rand(), 4'hF, resp);
         if (timeout_count == 0 && resp !== RESP_SLVERR) begin
            report_mismatch($sformatf("status write reg %0d resp", idx), RESP_SLVERR, resp);
         end
      end
      read_csr(0, `MCL_ID0, "ID0 after write");
      read_csr(1, `MCL_ID1, "ID1 after write");
      read_csr(2, 32'h0, "VDIP after write");
      read_csr(3, `MCL_NUM_COLS, "COLS after write");

      // Switches through the synchronizer
      repeat (8) begin
         r    = next_rand();
         vdip = r[15:0];
         @(negedge clk_main_a0);
         status_vdip_i = vdip;
         repeat (3) @(negedge clk_main_a0);
         read_csr(2, {16'h0000, vdip}, "VDIP read");
      end

      // Back-pressure on B and R
      bp_max = 6;
      repeat (150) begin
         col = next_rand() % `MCL_NUM_COLS;
         idx = next_rand() % `MCL_COL_WORDS;
         r   = next_rand();
         case (r[1:0])
            2'd0:    write_mem(col, idx, next_rand(), r[7:4], "stalled partial write");
            2'd1:    write_mem(col, idx, next_rand(), 4'hF, "stalled write");
            default: check_mem_read(col, idx, "stalled read");
         endcase
      end
      read_csr(0, `MCL_ID0, "ID0 after stalls");
      bp_max = 0;

      $display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+hdl
hdl/manycore_lite_pkg.sv
hdl/host_link_if.sv
hdl/col_link_if.sv
hdl/axil_host_port.sv
hdl/column_dispatch.sv
hdl/column_mem.sv
hdl/shell_status.sv
hdl/response_collect.sv
hdl/manycore_lite_top.sv
tb/tb_manycore_lite.sv
